//--- source/riscv_v_pkg.sv
//**************************************************
// Byte width, element sizes and ALU operation codes
// Helper to classify shift operations
//**************************************************

package riscv_v_pkg;

    localparam int BYTE_WIDTH = 8;
    localparam int NUM_OSIZES = 4;

    // Element size, bytes per element is 2**osize
    typedef enum logic [1:0] {
        OSIZE_8,
        OSIZE_16,
        OSIZE_32,
        OSIZE_64
    } osize_t;

    typedef enum logic [4:0] {
        OP_ADD, OP_SUB, OP_ADC,
        OP_MIN, OP_MAX, OP_MINU, OP_MAXU,
        OP_SEQ, OP_SNE, OP_SLT, OP_SLTU, OP_SGT, OP_SGTU,
        OP_SLL, OP_SRL, OP_SRA
    } alu_op_t;

    // Operations handled by the shift unit
    function automatic logic is_shift_op(input alu_op_t op);
        return op inside {OP_SLL, OP_SRL, OP_SRA};
    endfunction

endpackage

//--- source/riscv_v_alu_if.sv
//**************************************************
// Decoded operation and operands, decode stage to
// the execution units and the result stage
//**************************************************

`timescale 1ns/10ps

interface riscv_v_alu_if #(
    parameter int NUM_BYTES = 8
) ();

    logic                                               valid;
    riscv_v_pkg::alu_op_t                               op;
    riscv_v_pkg::osize_t                                osize;
    logic [NUM_BYTES-1:0][riscv_v_pkg::BYTE_WIDTH-1:0]  srca;
    logic [NUM_BYTES-1:0][riscv_v_pkg::BYTE_WIDTH-1:0]  srcb;
    logic [NUM_BYTES-1:0]                               srcb_valid;
    logic [NUM_BYTES-1:0]                               carry_in;

    // Decoded control levels
    logic is_sub, is_signed, use_carry, is_arithmetic, is_min_max, is_max;
    logic is_set_equal, is_set_nequal, is_set_less, is_set_greater;

    modport decode (
        output valid, op, osize, srca, srcb, srcb_valid, carry_in,
        output is_sub, is_signed, use_carry, is_arithmetic, is_min_max, is_max,
        output is_set_equal, is_set_nequal, is_set_less, is_set_greater
    );

    modport exec (
        input valid, op, osize, srca, srcb, srcb_valid, carry_in,
        input is_sub, is_signed, use_carry, is_arithmetic, is_min_max, is_max,
        input is_set_equal, is_set_nequal, is_set_less, is_set_greater
    );

    modport sel (input valid, op, srcb_valid);

endinterface

//--- source/adder_nbit.sv
//**************************************************
// Ripple-carry adder with carry into the top bit
//**************************************************

`timescale 1ns/10ps

module adder_nbit #(
    parameter int WIDTH = riscv_v_pkg::BYTE_WIDTH
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             cin,
    output logic [WIDTH-1:0] s,
    output logic             prev_cout,
    output logic             cout
);

    logic [WIDTH:0] carry;

    assign carry[0] = cin;

    for (genvar i = 0; i < WIDTH; i++) begin : gen_bit
        assign s[i]         = a[i] ^ b[i] ^ carry[i];
        assign carry[i + 1] = (a[i] & b[i]) | (carry[i] & (a[i] ^ b[i]));
    end

    // Carry into the MSB, used for signed overflow
    assign prev_cout = carry[WIDTH-1];
    assign cout      = carry[WIDTH];

endmodule

//--- source/riscv_v_adder.sv
//**************************************************
// Element-size-aware add, subtract, min/max and
// set-compare unit with per-byte flag vectors
//**************************************************

`timescale 1ns/10ps

module riscv_v_adder #(
    parameter int NUM_BYTES = 8
) (
    riscv_v_alu_if.exec                                 bus,
    output logic [NUM_BYTES-1:0][riscv_v_pkg::BYTE_WIDTH-1:0] add_result,
    output logic [NUM_BYTES-1:0]                        zf,
    output logic [NUM_BYTES-1:0]                        of,
    output logic [NUM_BYTES-1:0]                        cf
);

    localparam int BW = riscv_v_pkg::BYTE_WIDTH;

    logic [NUM_BYTES-1:0][BW-1:0] srca_g;
    logic [NUM_BYTES-1:0][BW-1:0] srcb_g;
    logic [NUM_BYTES-1:0][BW-1:0] srcb_adder;
    logic [NUM_BYTES-1:0][BW-1:0] sum;
    logic [NUM_BYTES-1:0][BW-1:0] min_max;

    // Byte b carries into byte b+1 of the same element
    logic [NUM_BYTES-1:0] merge;
    logic [NUM_BYTES-1:0] top;
    logic [NUM_BYTES-1:0] low;

    logic [NUM_BYTES-1:0] cin;
    logic [NUM_BYTES-1:0] prev_cout;
    logic [NUM_BYTES-1:0] cout;
    logic [NUM_BYTES-1:0] signed_of;
    logic [NUM_BYTES-1:0] unsigned_of;
    logic [NUM_BYTES-1:0] less_top;
    logic [NUM_BYTES-1:0] zero_run;
    logic [NUM_BYTES-1:0] equal_elem;
    logic [NUM_BYTES-1:0] less_elem;
    logic [NUM_BYTES-1:0] set_bit;

    // Element boundaries from osize
    always_comb begin
        for (int b = 0; b < NUM_BYTES; b++) begin
            merge[b] = (b < NUM_BYTES - 1) && (((b + 1) & ((1 << bus.osize) - 1)) != 0);
        end
        top    = ~merge;
        low[0] = 1'b1;
        for (int b = 1; b < NUM_BYTES; b++) begin
            low[b] = ~merge[b - 1];
        end
    end

    always_comb begin
        for (int b = 0; b < NUM_BYTES; b++) begin
            srca_g[b]     = bus.srca[b] & {BW{bus.valid}};
            srcb_g[b]     = bus.srcb[b] & {BW{bus.valid}};
            srcb_adder[b] = (srcb_g[b] ^ {BW{bus.is_sub}}) & {BW{bus.srcb_valid[b]}};
        end
    end

    for (genvar b = 0; b < NUM_BYTES; b++) begin : gen_adder
        // Carry restarts at each element boundary
        if (b == 0) begin : gen_first
            assign cin[b] = bus.use_carry ? bus.carry_in[b] : bus.is_sub;
        end else begin : gen_chain
            assign cin[b] = merge[b - 1] ? cout[b - 1]
                          : (bus.use_carry ? bus.carry_in[b] : bus.is_sub);
        end

        adder_nbit #(
            .WIDTH(BW)
        ) u_adder (
            .a         (srca_g[b]),
            .b         (srcb_adder[b]),
            .cin       (cin[b]),
            .s         (sum[b]),
            .prev_cout (prev_cout[b]),
            .cout      (cout[b])
        );
    end

    // Flags are meaningful only at each element's top byte
    always_comb begin
        for (int b = 0; b < NUM_BYTES; b++) begin
            signed_of[b]   = (cout[b] ^ prev_cout[b]) & bus.is_signed;
            unsigned_of[b] = (cout[b] ^ bus.is_sub) & ~bus.is_signed;
            less_top[b]    = bus.is_signed ? (sum[b][BW-1] ^ signed_of[b]) : unsigned_of[b];
        end
        zero_run[0] = (sum[0] == '0);
        for (int b = 1; b < NUM_BYTES; b++) begin
            zero_run[b] = (sum[b] == '0) & (low[b] | zero_run[b - 1]);
        end
        zf = zero_run & top;
        cf = cout & top;
        of = (signed_of | unsigned_of) & top;
    end

    // Spread element-wide compare outcome down to every byte
    always_comb begin
        equal_elem[NUM_BYTES-1] = zero_run[NUM_BYTES-1];
        less_elem[NUM_BYTES-1]  = less_top[NUM_BYTES-1];
        for (int b = NUM_BYTES - 2; b >= 0; b--) begin
            equal_elem[b] = top[b] ? zero_run[b] : equal_elem[b + 1];
            less_elem[b]  = top[b] ? less_top[b] : less_elem[b + 1];
        end
    end

    always_comb begin
        for (int b = 0; b < NUM_BYTES; b++) begin
            // Set value lands in the element's lowest byte
            set_bit[b] = low[b] & ((bus.is_set_equal & equal_elem[b])
                                 | (bus.is_set_nequal & ~equal_elem[b])
                                 | (bus.is_set_less & less_elem[b])
                                 | (bus.is_set_greater & ~less_elem[b] & ~equal_elem[b]));
            min_max[b] = (bus.is_max ^ less_elem[b]) ? srca_g[b] : srcb_g[b];
            add_result[b] = (sum[b] & {BW{bus.is_arithmetic}})
                          | (min_max[b] & {BW{bus.is_min_max}})
                          | {{(BW-1){1'b0}}, set_bit[b]};
        end
    end

endmodule

//--- source/riscv_v_shifter.sv
//**************************************************
// Per-element SLL, SRL and SRA for each osize
//**************************************************

`timescale 1ns/10ps

module riscv_v_shifter #(
    parameter int NUM_BYTES = 8
) (
    riscv_v_alu_if.exec                                       bus,
    output logic [NUM_BYTES-1:0][riscv_v_pkg::BYTE_WIDTH-1:0] shift_result
);

    localparam int BW    = riscv_v_pkg::BYTE_WIDTH;
    localparam int TOTAL = NUM_BYTES * BW;

    logic [TOTAL-1:0] a_flat;
    logic [TOTAL-1:0] b_flat;
    logic             shift_left;
    logic [TOTAL-1:0] shifted [riscv_v_pkg::NUM_OSIZES];

    assign a_flat     = bus.srca & {TOTAL{bus.valid}};
    assign b_flat     = bus.srcb & {TOTAL{bus.valid}};
    assign shift_left = (bus.op == riscv_v_pkg::OP_SLL);

    // One shifter bank per element size
    for (genvar o = 0; o < riscv_v_pkg::NUM_OSIZES; o++) begin : gen_size
        localparam int EB = 2 ** o;
        localparam int W  = BW * EB;

        if (EB <= NUM_BYTES) begin : gen_legal
            for (genvar e = 0; e < NUM_BYTES / EB; e++) begin : gen_elem
                logic [W-1:0]         a;
                logic [$clog2(W)-1:0] amt;
                logic [W:0]           a_ext;
                logic [W:0]           right;

                assign a   = a_flat[e*W +: W];
                // Amount from the low bits of the element's lowest srcb byte
                assign amt = b_flat[e*W +: $clog2(W)];
                // is_signed is clear for SRL, so only SRA sign fills
                assign a_ext = {bus.is_signed & a[W-1], a};
                assign right = $signed(a_ext) >>> amt;

                assign shifted[o][e*W +: W] = shift_left ? (a << amt) : right[W-1:0];
            end
        end else begin : gen_illegal
            assign shifted[o] = '0;
        end
    end

    assign shift_result = shifted[bus.osize];

endmodule

//--- source/riscv_v_op_decode.sv
//**************************************************
// Input register stage, decodes the operation code
// into control levels for the execution units
//**************************************************

`timescale 1ns/10ps

module riscv_v_op_decode #(
    parameter int NUM_BYTES = 8
) (
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic                                              in_valid,
    input  riscv_v_pkg::alu_op_t                              op,
    input  riscv_v_pkg::osize_t                               osize,
    input  logic [NUM_BYTES-1:0][riscv_v_pkg::BYTE_WIDTH-1:0] srca,
    input  logic [NUM_BYTES-1:0][riscv_v_pkg::BYTE_WIDTH-1:0] srcb,
    input  logic [NUM_BYTES-1:0]                              srcb_valid,
    input  logic [NUM_BYTES-1:0]                              carry_in,
    riscv_v_alu_if.decode                                     bus
);

    logic [9:0] ctrl;

    // Order: sub, signed, carry, arith, min_max, max, seq, sne, slt, sgt
    always_comb begin
        ctrl[9] = !riscv_v_pkg::is_shift_op(op)
                && !(op inside {riscv_v_pkg::OP_ADD, riscv_v_pkg::OP_ADC});
        ctrl[8] = !(op inside {riscv_v_pkg::OP_MINU, riscv_v_pkg::OP_MAXU,
                               riscv_v_pkg::OP_SLTU, riscv_v_pkg::OP_SGTU,
                               riscv_v_pkg::OP_SRL});
        ctrl[7] = (op == riscv_v_pkg::OP_ADC);
        ctrl[6] = op inside {riscv_v_pkg::OP_ADD, riscv_v_pkg::OP_SUB, riscv_v_pkg::OP_ADC};
        ctrl[5] = op inside {riscv_v_pkg::OP_MIN, riscv_v_pkg::OP_MAX,
                             riscv_v_pkg::OP_MINU, riscv_v_pkg::OP_MAXU};
        ctrl[4] = op inside {riscv_v_pkg::OP_MAX, riscv_v_pkg::OP_MAXU};
        ctrl[3] = (op == riscv_v_pkg::OP_SEQ);
        ctrl[2] = (op == riscv_v_pkg::OP_SNE);
        ctrl[1] = op inside {riscv_v_pkg::OP_SLT, riscv_v_pkg::OP_SLTU};
        ctrl[0] = op inside {riscv_v_pkg::OP_SGT, riscv_v_pkg::OP_SGTU};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.valid <= 1'b0;
            {bus.is_sub, bus.is_signed, bus.use_carry, bus.is_arithmetic, bus.is_min_max,
             bus.is_max, bus.is_set_equal, bus.is_set_nequal, bus.is_set_less,
             bus.is_set_greater} <= '0;
        end else begin
            bus.valid <= in_valid;
            if (in_valid) begin
                {bus.is_sub, bus.is_signed, bus.use_carry, bus.is_arithmetic, bus.is_min_max,
                 bus.is_max, bus.is_set_equal, bus.is_set_nequal, bus.is_set_less,
                 bus.is_set_greater} <= ctrl;
            end
        end
    end

    // Operand registers
    always_ff @(posedge clk) begin
        if (in_valid) begin
            bus.op         <= op;
            bus.osize      <= osize;
            bus.srca       <= srca;
            bus.srcb       <= srcb;
            bus.srcb_valid <= srcb_valid;
            bus.carry_in   <= carry_in;
        end
    end

endmodule

//--- source/riscv_v_result_sel.sv
//**************************************************
// Output register stage, result and flag select
// with the srcb byte valid mask
//**************************************************

`timescale 1ns/10ps

module riscv_v_result_sel #(
    parameter int NUM_BYTES = 8
) (
    input  logic                                              clk,
    input  logic                                              reset,
    riscv_v_alu_if.sel                                        bus,
    input  logic [NUM_BYTES-1:0][riscv_v_pkg::BYTE_WIDTH-1:0] add_result,
    input  logic [NUM_BYTES-1:0]                              zf,
    input  logic [NUM_BYTES-1:0]                              of,
    input  logic [NUM_BYTES-1:0]                              cf,
    input  logic [NUM_BYTES-1:0][riscv_v_pkg::BYTE_WIDTH-1:0] shift_result,
    output logic                                              out_valid,
    output logic [NUM_BYTES-1:0][riscv_v_pkg::BYTE_WIDTH-1:0] result,
    output logic [NUM_BYTES-1:0]                              zf_q,
    output logic [NUM_BYTES-1:0]                              of_q,
    output logic [NUM_BYTES-1:0]                              cf_q
);

    localparam int BW = riscv_v_pkg::BYTE_WIDTH;

    logic                         is_shift;
    logic [NUM_BYTES-1:0][BW-1:0] masked;

    assign is_shift = riscv_v_pkg::is_shift_op(bus.op);

    always_comb begin
        for (int b = 0; b < NUM_BYTES; b++) begin
            masked[b] = (is_shift ? shift_result[b] : add_result[b]) & {BW{bus.srcb_valid[b]}};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            result    <= '0;
            zf_q      <= '0;
            of_q      <= '0;
            cf_q      <= '0;
        end else begin
            out_valid <= bus.valid;
            if (bus.valid) begin
                result <= masked;
                // Shifts produce no flags
                zf_q   <= is_shift ? '0 : zf;
                of_q   <= is_shift ? '0 : of;
                cf_q   <= is_shift ? '0 : cf;
            end
        end
    end

endmodule

//--- source/riscv_v_alu.sv
//**************************************************
// SIMD integer ALU top, decode stage, adder and
// shifter units, result register stage
//**************************************************

`timescale 1ns/10ps

module riscv_v_alu #(
    parameter int NUM_BYTES = 8
) (
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic                                              in_valid,
    input  riscv_v_pkg::alu_op_t                              op,
    input  riscv_v_pkg::osize_t                               osize,
    input  logic [NUM_BYTES-1:0][riscv_v_pkg::BYTE_WIDTH-1:0] srca,
    input  logic [NUM_BYTES-1:0][riscv_v_pkg::BYTE_WIDTH-1:0] srcb,
    input  logic [NUM_BYTES-1:0]                              srcb_valid,
    input  logic [NUM_BYTES-1:0]                              carry_in,
    output logic                                              out_valid,
    output logic [NUM_BYTES-1:0][riscv_v_pkg::BYTE_WIDTH-1:0] result,
    output logic [NUM_BYTES-1:0]                              zf,
    output logic [NUM_BYTES-1:0]                              of,
    output logic [NUM_BYTES-1:0]                              cf
);

    logic [NUM_BYTES-1:0][riscv_v_pkg::BYTE_WIDTH-1:0] add_result;
    logic [NUM_BYTES-1:0][riscv_v_pkg::BYTE_WIDTH-1:0] shift_result;
    logic [NUM_BYTES-1:0]                              add_zf;
    logic [NUM_BYTES-1:0]                              add_of;
    logic [NUM_BYTES-1:0]                              add_cf;

    riscv_v_alu_if #(.NUM_BYTES(NUM_BYTES)) alu_bus ();

    riscv_v_op_decode #(.NUM_BYTES(NUM_BYTES)) u_decode (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .op         (op),
        .osize      (osize),
        .srca       (srca),
        .srcb       (srcb),
        .srcb_valid (srcb_valid),
        .carry_in   (carry_in),
        .bus        (alu_bus.decode)
    );

    riscv_v_adder #(.NUM_BYTES(NUM_BYTES)) u_adder (
        .bus        (alu_bus.exec),
        .add_result (add_result),
        .zf         (add_zf),
        .of         (add_of),
        .cf         (add_cf)
    );

    riscv_v_shifter #(.NUM_BYTES(NUM_BYTES)) u_shifter (
        .bus          (alu_bus.exec),
        .shift_result (shift_result)
    );

    riscv_v_result_sel #(.NUM_BYTES(NUM_BYTES)) u_result_sel (
        .clk          (clk),
        .reset        (reset),
        .bus          (alu_bus.sel),
        .add_result   (add_result),
        .zf           (add_zf),
        .of           (add_of),
        .cf           (add_cf),
        .shift_result (shift_result),
        .out_valid    (out_valid),
        .result       (result),
        .zf_q         (zf),
        .of_q         (of),
        .cf_q         (cf)
    );

endmodule

//--- sim/tb_riscv_v_alu.sv
//**************************************************
// SIMD ALU testbench, clock and reset, random
// stimulus, per-element model and assertions
//**************************************************

`timescale 1ns/10ps

module tb_riscv_v_alu;

    localparam int NB          = 8;
    localparam int BW          = riscv_v_pkg::BYTE_WIDTH;
    localparam int TW          = NB * BW;
    localparam int N_OPS       = 600;
    localparam int DRAIN_LIMIT = 20;

    typedef struct packed {
        logic [TW-1:0] result;
        logic [NB-1:0] zf;
        logic [NB-1:0] of;
        logic [NB-1:0] cf;
    } expect_t;

    logic                  clk, reset, in_valid, out_valid;
    riscv_v_pkg::alu_op_t  op;
    riscv_v_pkg::osize_t   osize;
    logic [NB-1:0][BW-1:0] srca, srcb, result;
    logic [NB-1:0]         srcb_valid, carry_in, zf, of, cf;

    integer  seed   = 32'h6842;
    logic    vld_d1 = 1'b0;
    logic    vld_d2 = 1'b0;
    expect_t exp_q[$];
    expect_t head;

    riscv_v_alu #(.NUM_BYTES(NB)) uut (
        .clk(clk), .reset(reset), .in_valid(in_valid), .op(op), .osize(osize),
        .srca(srca), .srcb(srcb), .srcb_valid(srcb_valid), .carry_in(carry_in),
        .out_valid(out_valid), .result(result), .zf(zf), .of(of), .cf(cf)
    );

    task automatic flag_error(input string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // Per-element reference, flags sit at the element's top byte
    function automatic expect_t expected_outputs(
        input riscv_v_pkg::alu_op_t cur_op, input riscv_v_pkg::osize_t cur_size,
        input logic [TW-1:0] a_in, input logic [TW-1:0] b_in,
        input logic [NB-1:0] bv_in, input logic [NB-1:0] ci_in);
        expect_t       res;
        int            eb, w, top, amt;
        logic [64:0]   mask, ea, raw_b, badd, sum_full, low_full, elem;
        logic [BW-1:0] bt;
        logic          sub, sgn, cin, cout, sof, uof, lt, eq;

        res  = '0;
        eb   = 1 << cur_size;
        w    = eb * BW;
        mask = (65'd1 << w) - 65'd1;
        sub  = cur_op inside {riscv_v_pkg::OP_SUB, riscv_v_pkg::OP_MIN, riscv_v_pkg::OP_MAX,
                              riscv_v_pkg::OP_MINU, riscv_v_pkg::OP_MAXU, riscv_v_pkg::OP_SEQ,
                              riscv_v_pkg::OP_SNE, riscv_v_pkg::OP_SLT, riscv_v_pkg::OP_SLTU,
                              riscv_v_pkg::OP_SGT, riscv_v_pkg::OP_SGTU};
        sgn  = !(cur_op inside {riscv_v_pkg::OP_MINU, riscv_v_pkg::OP_MAXU, riscv_v_pkg::OP_SLTU,
                                riscv_v_pkg::OP_SGTU, riscv_v_pkg::OP_SRL});
        for (int e = 0; e < NB / eb; e++) begin
            ea    = {1'b0, a_in >> (e * w)} & mask;
            raw_b = {1'b0, b_in >> (e * w)} & mask;
            badd  = '0;
            // Inverted for subtract, then zeroed where the byte is not valid
            for (int k = 0; k < eb; k++) begin
                bt = b_in[(e * eb + k) * BW +: BW];
                bt = sub ? ~bt : bt;
                badd[k * BW +: BW] = bv_in[e * eb + k] ? bt : '0;
            end
            cin      = (cur_op == riscv_v_pkg::OP_ADC) ? ci_in[e * eb] : sub;
            sum_full = ea + badd + {64'd0, cin};
            low_full = (ea & (mask >> 1)) + (badd & (mask >> 1)) + {64'd0, cin};
            cout     = sum_full[w];
            sof      = sgn & (cout ^ low_full[w - 1]);
            uof      = !sgn & (cout ^ sub);
            lt       = sgn ? (sum_full[w - 1] ^ sof) : uof;
            eq       = ((sum_full & mask) == '0);
            amt      = int'(raw_b[5:0]) & (w - 1);
            top      = e * eb + eb - 1;
            case (cur_op)
                riscv_v_pkg::OP_MIN, riscv_v_pkg::OP_MINU: elem = lt ? ea : raw_b;
                riscv_v_pkg::OP_MAX, riscv_v_pkg::OP_MAXU: elem = lt ? raw_b : ea;
                riscv_v_pkg::OP_SEQ:                       elem = {64'd0, eq};
                riscv_v_pkg::OP_SNE:                       elem = {64'd0, !eq};
                riscv_v_pkg::OP_SLT, riscv_v_pkg::OP_SLTU: elem = {64'd0, lt};
                riscv_v_pkg::OP_SGT, riscv_v_pkg::OP_SGTU: elem = {64'd0, !lt && !eq};
                riscv_v_pkg::OP_SLL:                       elem = ea << amt;
                riscv_v_pkg::OP_SRL:                       elem = ea >> amt;
                riscv_v_pkg::OP_SRA: elem = (ea >> amt) | (ea[w - 1] ? ~(mask >> amt) : '0);
                default:                                   elem = sum_full;
            endcase
            res.result = res.result | ((elem[TW-1:0] & mask[TW-1:0]) << (e * w));
            if (!riscv_v_pkg::is_shift_op(cur_op)) begin
                res.zf[top] = eq;
                res.cf[top] = cout;
                res.of[top] = sof | uof;
            end
        end
        for (int i = 0; i < NB; i++) begin
            if (!bv_in[i]) res.result[i * BW +: BW] = '0;
        end
        return res;
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Expected out_valid, two cycles behind in_valid
    always @(posedge clk) begin
        vld_d1 <= in_valid;
        vld_d2 <= vld_d1;
    end

    assert property (@(posedge clk) disable iff (reset) out_valid == vld_d2)
        else flag_error($sformatf("[ERROR] out_valid: got %h, expected %h",
                                  $sampled(out_valid), $sampled(vld_d2)));

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!reset && out_valid) begin
            if (exp_q.size() == 0) begin
                flag_error("out_valid went high with no operation outstanding");
            end else begin
                head = exp_q.pop_front();
                assert (result == head.result)
                    else flag_error($sformatf("[ERROR] result: got %h, expected %h",
                                              result, head.result));
                assert (zf == head.zf)
                    else flag_error($sformatf("[ERROR] zf: got %h, expected %h", zf, head.zf));
                assert (of == head.of)
                    else flag_error($sformatf("[ERROR] of: got %h, expected %h", of, head.of));
                assert (cf == head.cf)
                    else flag_error($sformatf("[ERROR] cf: got %h, expected %h", cf, head.cf));
            end
        end
    end

    initial begin
        logic [31:0]   r;
        logic [TW-1:0] a_v, b_v;
        logic [NB-1:0] bv_v;
        logic          idle;

        reset = 1'b1;
        in_valid = 1'b0;
        op = riscv_v_pkg::OP_ADD;
        osize = riscv_v_pkg::OSIZE_8;
        srca = '0;
        srcb = '0;
        srcb_valid = '0;
        carry_in = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!out_valid && result == '0 && {zf, of, cf} == '0)
            else flag_error($sformatf("[ERROR] out_valid/result/flags after reset: got %h, expected %h",
                                      {out_valid, result, zf, of, cf}, 89'h0));

        for (int n = 0; n < N_OPS; n++) begin
            @(posedge clk);
            r = $random(seed);
            a_v[63:32] = $random(seed);
            a_v[31:0] = $random(seed);
            b_v[63:32] = $random(seed);
            b_v[31:0] = $random(seed);
            // Equal operands now and then, for SEQ and the zero flag
            if (r[15:13] == 3'd0) b_v = a_v;
            bv_v = (r[9:8] == 2'd0) ? r[31:24] : '1;
            idle = (r[12:10] == 3'd0);
            in_valid   <= !idle;
            op         <= riscv_v_pkg::alu_op_t'({1'b0, r[3:0]});
            osize      <= riscv_v_pkg::osize_t'(r[5:4]);
            srca       <= a_v;
            srcb       <= b_v;
            srcb_valid <= bv_v;
            carry_in   <= r[23:16];
            if (!idle) begin
                exp_q.push_back(expected_outputs(riscv_v_pkg::alu_op_t'({1'b0, r[3:0]}),
                                                 riscv_v_pkg::osize_t'(r[5:4]),
                                                 a_v, b_v, bv_v, r[23:16]));
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;

        for (int t = 0; t < DRAIN_LIMIT && exp_q.size() != 0; t++) @(posedge clk);
        if (exp_q.size() != 0) begin
            flag_error("Timed out waiting for the remaining results");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

//--- vlog.f
source/riscv_v_pkg.sv
source/riscv_v_alu_if.sv
source/adder_nbit.sv
source/riscv_v_adder.sv
source/riscv_v_shifter.sv
source/riscv_v_op_decode.sv
source/riscv_v_result_sel.sv
source/riscv_v_alu.sv
sim/tb_riscv_v_alu.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_riscv_v_alu
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
